/* project.f */
rtl/axi_pkg.sv
rtl/request_queue.sv
rtl/axi_master.sv
rtl/axi_slave_memory.sv
rtl/axi_subsystem.sv
testbench/axi_subsystem_tb.sv

/* rtl/axi_master.sv */
`timescale 1ns/10ps

module axi_master (
    input  logic axi_ACLK,
    input  logic axi_ARESETN,

    // Write queue
    input  logic                    write_empty_i,
    input  axi_pkg::write_request_t write_request_i,
    output logic                    write_pop_o,

    // Read queue
    input  logic                   read_empty_i,
    input  axi_pkg::read_request_t read_request_i,
    output logic                   read_pop_o,

    // Router flow control
    input  logic router_write_cts_i,
    input  logic router_read_cts_i,

    // Write address and data channels
    output logic [axi_pkg::ADDR_WIDTH-1:0] awaddr_o,
    output logic                           awvalid_o,
    input  logic                           awready_i,
    output logic [axi_pkg::DATA_WIDTH-1:0] wdata_o,
    output logic [axi_pkg::STRB_WIDTH-1:0] wstrb_o,
    output logic                           wvalid_o,
    input  logic                           wready_i,

    // Write response channel
    input  axi_pkg::axi_response_t bresp_i,
    input  logic                   bvalid_i,
    output logic                   bready_o,

    // Read address channel
    output logic [axi_pkg::ADDR_WIDTH-1:0] araddr_o,
    output logic                           arvalid_o,
    input  logic                           arready_i,

    // Read data channel
    input  logic [axi_pkg::DATA_WIDTH-1:0] rdata_i,
    input  axi_pkg::axi_response_t         rresp_i,
    input  logic                           rvalid_i,
    output logic                           rready_o,

    // Transaction results
    output logic                           write_done_o,
    output axi_pkg::axi_response_t         write_response_o,
    output logic                           read_done_o,
    output logic [axi_pkg::DATA_WIDTH-1:0] read_data_o,
    output axi_pkg::axi_response_t         read_response_o
);

    logic write_pending;
    logic write_start;
    logic write_flush;
    logic read_pending;
    logic read_start;
    logic read_flush;

    // Write channel

    // Response accepted only while the router lets it through
    assign bready_o = router_write_cts_i;
    assign write_done_o = bvalid_i & bready_o;
    assign write_response_o = bresp_i;

    // Slave error drops everything on this channel
    assign write_flush = write_done_o & (bresp_i == axi_pkg::SLVERR);

    // One transaction at a time, only with a free route
    assign write_start = !write_empty_i & !write_pending & router_write_cts_i & !write_flush;
    // Head is taken in the same cycle
    assign write_pop_o = write_start;

    // Request loaded onto the bus at start
    always_ff @(posedge axi_ACLK) begin
        if (write_start) begin
            awaddr_o <= write_request_i.addr;
            wdata_o  <= write_request_i.data;
            wstrb_o  <= write_request_i.strobe;
        end
    end

    always_ff @(posedge axi_ACLK) begin
        if (!axi_ARESETN) begin
            awvalid_o     <= 1'b0;
            wvalid_o      <= 1'b0;
            write_pending <= 1'b0;
        end else if (write_start) begin
            // VALID one cycle after the pop
            awvalid_o     <= 1'b1;
            wvalid_o      <= 1'b1;
            write_pending <= 1'b1;
        end else begin
            // Each VALID falls on its own handshake, never on a lost route
            if ((awvalid_o & awready_i) | write_flush) begin
                awvalid_o <= 1'b0;
            end
            if ((wvalid_o & wready_i) | write_flush) begin
                wvalid_o <= 1'b0;
            end
            // Channel free again once the response is taken
            if (write_done_o) begin
                write_pending <= 1'b0;
            end
        end
    end

    // Read channel

    assign rready_o = router_read_cts_i;
    assign read_done_o = rvalid_i & rready_o;
    assign read_data_o = rdata_i;
    assign read_response_o = rresp_i;

    assign read_flush = read_done_o & (rresp_i == axi_pkg::SLVERR);

    assign read_start = !read_empty_i & !read_pending & router_read_cts_i & !read_flush;
    assign read_pop_o = read_start;

    always_ff @(posedge axi_ACLK) begin
        if (read_start) begin
            araddr_o <= read_request_i.addr;
        end
    end

    always_ff @(posedge axi_ACLK) begin
        if (!axi_ARESETN) begin
            arvalid_o    <= 1'b0;
            read_pending <= 1'b0;
        end else if (read_start) begin
            arvalid_o    <= 1'b1;
            read_pending <= 1'b1;
        end else begin
            if ((arvalid_o & arready_i) | read_flush) begin
                arvalid_o <= 1'b0;
            end
            if (read_done_o) begin
                read_pending <= 1'b0;
            end
        end
    end

    // Nothing starts on a flush cycle, so the bus is quiet just after
    assert property (@(posedge axi_ACLK) disable iff (!axi_ARESETN)
        write_flush |=> !awvalid_o & !wvalid_o);
    assert property (@(posedge axi_ACLK) disable iff (!axi_ARESETN)
        read_flush |=> !arvalid_o);

    // VALID stays up until the slave takes it
    assert property (@(posedge axi_ACLK) disable iff (!axi_ARESETN)
        (awvalid_o & !awready_i) |=> awvalid_o);
    assert property (@(posedge axi_ACLK) disable iff (!axi_ARESETN)
        (arvalid_o & !arready_i) |=> arvalid_o);

endmodule : axi_master

/* rtl/axi_pkg.sv */
package axi_pkg;

    // Bus sizing
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // Slave memory sizing, base address is zero
    localparam int MEM_WORDS = 16;
    localparam int MEM_INDEX_WIDTH = $clog2(MEM_WORDS);
    localparam int BYTE_OFFSET_WIDTH = $clog2(STRB_WIDTH);
    // First byte address past the memory
    localparam int unsigned MEM_BYTES = MEM_WORDS * STRB_WIDTH;

    // Request queue sizing
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
    // One extra bit so a full queue can be counted
    localparam int QUEUE_COUNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

    // AXI response codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_response_t;

    // Write request, 68 bits
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strobe;
    } write_request_t;

    // Read request, address only
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
    } read_request_t;

endpackage : axi_pkg

/* rtl/axi_slave_memory.sv */
`timescale 1ns/10ps

module axi_slave_memory (
    input  logic axi_ACLK,
    input  logic axi_ARESETN,

    // Write address and data channels
    input  logic [axi_pkg::ADDR_WIDTH-1:0] awaddr_i,
    input  logic                           awvalid_i,
    output logic                           awready_o,
    input  logic [axi_pkg::DATA_WIDTH-1:0] wdata_i,
    input  logic [axi_pkg::STRB_WIDTH-1:0] wstrb_i,
    input  logic                           wvalid_i,
    output logic                           wready_o,

    // Write response channel
    output axi_pkg::axi_response_t bresp_o,
    output logic                   bvalid_o,
    input  logic                   bready_i,

    // Read address channel
    input  logic [axi_pkg::ADDR_WIDTH-1:0] araddr_i,
    input  logic                           arvalid_i,
    output logic                           arready_o,

    // Read data channel
    output logic [axi_pkg::DATA_WIDTH-1:0] rdata_o,
    output axi_pkg::axi_response_t         rresp_o,
    output logic                           rvalid_o,
    input  logic                           rready_i
);

    // Word storage
    logic [axi_pkg::DATA_WIDTH-1:0] mem [axi_pkg::MEM_WORDS];

    logic write_accept;
    logic write_in_range;
    logic [axi_pkg::MEM_INDEX_WIDTH-1:0] write_index;
    logic read_accept;
    logic read_in_range;
    logic [axi_pkg::MEM_INDEX_WIDTH-1:0] read_index;

    // Ready while no response is waiting
    assign awready_o = !bvalid_o;
    assign wready_o = !bvalid_o;
    assign arready_o = !rvalid_o;

    // Address and data are taken together
    assign write_accept = awvalid_i & wvalid_i & awready_o & wready_o;
    assign read_accept = arvalid_i & arready_o;

    // Range check against the byte size of the memory
    assign write_in_range = (awaddr_i < axi_pkg::MEM_BYTES);
    assign read_in_range = (araddr_i < axi_pkg::MEM_BYTES);

    // Word index, byte offset dropped
    assign write_index = awaddr_i[axi_pkg::BYTE_OFFSET_WIDTH +: axi_pkg::MEM_INDEX_WIDTH];
    assign read_index = araddr_i[axi_pkg::BYTE_OFFSET_WIDTH +: axi_pkg::MEM_INDEX_WIDTH];

    // Memory and response valid flags
    always_ff @(posedge axi_ACLK) begin
        if (!axi_ARESETN) begin
            for (int i = 0; i < axi_pkg::MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
            bvalid_o <= 1'b0;
            rvalid_o <= 1'b0;
        end else begin
            if (write_accept) begin
                bvalid_o <= 1'b1;
                // Merge bytes under the strobe, out of range leaves memory alone
                if (write_in_range) begin
                    for (int b = 0; b < axi_pkg::STRB_WIDTH; b++) begin
                        if (wstrb_i[b]) begin
                            mem[write_index][b*8 +: 8] <= wdata_i[b*8 +: 8];
                        end
                    end
                end
            end else if (bvalid_o & bready_i) begin
                bvalid_o <= 1'b0;
            end

            if (read_accept) begin
                rvalid_o <= 1'b1;
            end else if (rvalid_o & rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

    // Response payload, held while VALID waits
    always_ff @(posedge axi_ACLK) begin
        if (write_accept) begin
            bresp_o <= write_in_range ? axi_pkg::OKAY : axi_pkg::SLVERR;
        end
        if (read_accept) begin
            rresp_o <= read_in_range ? axi_pkg::OKAY : axi_pkg::SLVERR;
            // Zero data on a bad address
            rdata_o <= read_in_range ? mem[read_index] : '0;
        end
    end

    // Responses wait for the master
    assert property (@(posedge axi_ACLK) disable iff (!axi_ARESETN)
        (bvalid_o & !bready_i) |=> bvalid_o);
    assert property (@(posedge axi_ACLK) disable iff (!axi_ARESETN)
        (rvalid_o & !rready_i) |=> rvalid_o);

endmodule : axi_slave_memory

/* rtl/axi_subsystem.sv */
`timescale 1ns/10ps

module axi_subsystem (
    input  logic axi_ACLK,
    input  logic axi_ARESETN,

    // Request entry
    input  logic                    write_push_i,
    input  axi_pkg::write_request_t write_request_i,
    output logic                    write_full_o,
    input  logic                    read_push_i,
    input  axi_pkg::read_request_t  read_request_i,
    output logic                    read_full_o,

    // Interconnect stand-in
    input  logic router_write_cts_i,
    input  logic router_read_cts_i,

    // Results
    output logic                           write_done_o,
    output axi_pkg::axi_response_t         write_response_o,
    output logic                           read_done_o,
    output logic [axi_pkg::DATA_WIDTH-1:0] read_data_o,
    output axi_pkg::axi_response_t         read_response_o
);

    // Queue heads toward the master
    axi_pkg::write_request_t write_head;
    axi_pkg::read_request_t  read_head;
    logic write_empty;
    logic write_pop;
    logic read_empty;
    logic read_pop;

    // AXI-Lite bus between master and slave
    logic [axi_pkg::ADDR_WIDTH-1:0] awaddr;
    logic awvalid;
    logic awready;
    logic [axi_pkg::DATA_WIDTH-1:0] wdata;
    logic [axi_pkg::STRB_WIDTH-1:0] wstrb;
    logic wvalid;
    logic wready;
    axi_pkg::axi_response_t bresp;
    logic bvalid;
    logic bready;
    logic [axi_pkg::ADDR_WIDTH-1:0] araddr;
    logic arvalid;
    logic arready;
    logic [axi_pkg::DATA_WIDTH-1:0] rdata;
    axi_pkg::axi_response_t rresp;
    logic rvalid;
    logic rready;

    request_queue #(.payload_t(axi_pkg::write_request_t)) write_queue (
        .axi_ACLK(axi_ACLK), .axi_ARESETN(axi_ARESETN),
        .push_i(write_push_i), .data_i(write_request_i),
        .pop_i(write_pop), .data_o(write_head),
        .empty_o(write_empty), .full_o(write_full_o)
    );

    request_queue #(.payload_t(axi_pkg::read_request_t)) read_queue (
        .axi_ACLK(axi_ACLK), .axi_ARESETN(axi_ARESETN),
        .push_i(read_push_i), .data_i(read_request_i),
        .pop_i(read_pop), .data_o(read_head),
        .empty_o(read_empty), .full_o(read_full_o)
    );

    axi_master master (
        .axi_ACLK(axi_ACLK), .axi_ARESETN(axi_ARESETN),
        .write_empty_i(write_empty), .write_request_i(write_head), .write_pop_o(write_pop),
        .read_empty_i(read_empty), .read_request_i(read_head), .read_pop_o(read_pop),
        .router_write_cts_i(router_write_cts_i), .router_read_cts_i(router_read_cts_i),
        .awaddr_o(awaddr), .awvalid_o(awvalid), .awready_i(awready),
        .wdata_o(wdata), .wstrb_o(wstrb), .wvalid_o(wvalid), .wready_i(wready),
        .bresp_i(bresp), .bvalid_i(bvalid), .bready_o(bready),
        .araddr_o(araddr), .arvalid_o(arvalid), .arready_i(arready),
        .rdata_i(rdata), .rresp_i(rresp), .rvalid_i(rvalid), .rready_o(rready),
        .write_done_o(write_done_o), .write_response_o(write_response_o),
        .read_done_o(read_done_o), .read_data_o(read_data_o),
        .read_response_o(read_response_o)
    );

    axi_slave_memory slave_memory (
        .axi_ACLK(axi_ACLK), .axi_ARESETN(axi_ARESETN),
        .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
        .wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o(wready),
        .bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready),
        .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
        .rdata_o(rdata), .rresp_o(rresp), .rvalid_o(rvalid), .rready_i(rready)
    );

endmodule : axi_subsystem

/* rtl/request_queue.sv */
`timescale 1ns/10ps

module request_queue #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     axi_ACLK,
    input  logic     axi_ARESETN,

    // Producer side
    input  logic     push_i,
    input  payload_t data_i,

    // Consumer side, head is registered
    input  logic     pop_i,
    output payload_t data_o,
    output logic     empty_o,
    output logic     full_o
);

    // Storage, no reset needed on payload
    payload_t mem [axi_pkg::QUEUE_DEPTH];

    logic [axi_pkg::QUEUE_PTR_WIDTH-1:0] wr_ptr;
    logic [axi_pkg::QUEUE_PTR_WIDTH-1:0] rd_ptr;
    logic [axi_pkg::QUEUE_PTR_WIDTH-1:0] next_rd_ptr;
    logic [axi_pkg::QUEUE_COUNT_WIDTH-1:0] count;
    logic [axi_pkg::QUEUE_COUNT_WIDTH-1:0] next_count;
    logic push_ok;
    logic pop_ok;

    // Push into a full queue is dropped
    assign push_ok = push_i & !full_o;
    // Pop of an empty queue is ignored
    assign pop_ok = pop_i & !empty_o;
    // Depth is a power of two, pointer wraps by itself
    assign next_rd_ptr = rd_ptr + 1'b1;

    // Occupancy after this cycle
    always_comb begin
        next_count = count;
        if (push_ok & !pop_ok) begin
            next_count = count + 1'b1;
        end else if (!push_ok & pop_ok) begin
            next_count = count - 1'b1;
        end
    end

    // Pointers, count and flags
    always_ff @(posedge axi_ACLK) begin
        if (!axi_ARESETN) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            empty_o <= 1'b1;
            full_o  <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= next_rd_ptr;
            end
            count   <= next_count;
            empty_o <= (next_count == '0);
            full_o  <= (next_count == axi_pkg::QUEUE_DEPTH);
        end
    end

    // Storage write and registered head
    always_ff @(posedge axi_ACLK) begin
        if (push_ok) begin
            mem[wr_ptr] <= data_i;
        end
        if (pop_ok) begin
            // Next entry becomes head, or the incoming one if the queue drains
            if (count > 'd1) begin
                data_o <= mem[next_rd_ptr];
            end else if (push_ok) begin
                data_o <= data_i;
            end
        end else if (push_ok & empty_o) begin
            // First entry goes straight to the head
            data_o <= data_i;
        end
    end

    // Consumer never pops an empty queue
    assert property (@(posedge axi_ACLK) disable iff (!axi_ARESETN) pop_i |-> !empty_o);

    // Occupancy stays within the depth
    assert property (@(posedge axi_ACLK) disable iff (!axi_ARESETN)
        count <= axi_pkg::QUEUE_DEPTH);

endmodule : request_queue

/* run_sim.sh */
#!/bin/sh
# Build and run the AXI-Lite subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module axi_subsystem_tb -o axi_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/axi_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

/* testbench/axi_subsystem_tb.sv */
`timescale 1ns/10ps

module axi_subsystem_tb;

    logic axi_ACLK;
    logic axi_ARESETN;
    logic write_push_i;
    axi_pkg::write_request_t write_request_i;
    logic write_full_o;
    logic read_push_i;
    axi_pkg::read_request_t read_request_i;
    logic read_full_o;
    logic router_write_cts_i;
    logic router_read_cts_i;
    logic write_done_o;
    axi_pkg::axi_response_t write_response_o;
    logic read_done_o;
    logic [axi_pkg::DATA_WIDTH-1:0] read_data_o;
    axi_pkg::axi_response_t read_response_o;

    // File contents, one entry per request or phase marker
    byte kind_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] data_q[$];
    logic [31:0] aux_q[$];

    // Requests of the phase being run
    axi_pkg::write_request_t wr_q[$];
    axi_pkg::read_request_t rd_q[$];

    // Expected results in channel order
    axi_pkg::axi_response_t exp_wr_resp[$];
    axi_pkg::axi_response_t exp_rd_resp[$];
    logic [axi_pkg::DATA_WIDTH-1:0] exp_rd_data[$];

    // Reference memory, word addressed from zero
    logic [axi_pkg::DATA_WIDTH-1:0] ref_mem [axi_pkg::MEM_WORDS];

    int value_errors = 0;
    int other_errors = 0;
    int request_count = 0;
    int wr_target = 0;
    int rd_target = 0;
    int wr_accepted = 0;
    int rd_accepted = 0;
    int wr_done_count = 0;
    int rd_done_count = 0;
    logic phase_done;
    logic saw_write_full;
    logic saw_read_full;

    axi_subsystem UUT (
        .axi_ACLK(axi_ACLK), .axi_ARESETN(axi_ARESETN),
        .write_push_i(write_push_i), .write_request_i(write_request_i),
        .write_full_o(write_full_o),
        .read_push_i(read_push_i), .read_request_i(read_request_i),
        .read_full_o(read_full_o),
        .router_write_cts_i(router_write_cts_i), .router_read_cts_i(router_read_cts_i),
        .write_done_o(write_done_o), .write_response_o(write_response_o),
        .read_done_o(read_done_o), .read_data_o(read_data_o),
        .read_response_o(read_response_o)
    );

    // 8 ns period
    initial axi_ACLK = 1'b0;
    always #4 axi_ACLK = ~axi_ACLK;

    task automatic check_response(input string name, input axi_pkg::axi_response_t expected,
                                  input axi_pkg::axi_response_t actual);
        if (expected !== actual) begin
            value_errors++;
            $display("ERROR at %0t: %s expected %s, got %s", $time, name,
                     expected.name(), actual.name());
        end
    endtask

    task automatic check_data(input string name, input logic [axi_pkg::DATA_WIDTH-1:0] expected,
                              input logic [axi_pkg::DATA_WIDTH-1:0] actual);
        if (expected !== actual) begin
            value_errors++;
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // Range rule of the slave, only the first 64 bytes exist
    function automatic axi_pkg::axi_response_t predict_response(input logic [31:0] addr);
        return (addr < axi_pkg::MEM_WORDS * 4) ? axi_pkg::OKAY : axi_pkg::SLVERR;
    endfunction

    // Parse the data file and build expected results in request order
    task automatic load_requests(input int fd);
        string line;
        byte kind;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] s;
        logic [31:0] model;
        int n;
        begin
            for (int i = 0; i < axi_pkg::MEM_WORDS; i++) begin
                ref_mem[i] = '0;
            end
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h %h", kind, a, d, s);
                    kind_q.push_back(kind);
                    addr_q.push_back(a);
                    data_q.push_back(d);
                    aux_q.push_back(s);
                    if (kind == "W") begin
                        request_count++;
                        exp_wr_resp.push_back(predict_response(a));
                        // Byte merge under the strobe, bad addresses change nothing
                        if (predict_response(a) == axi_pkg::OKAY) begin
                            for (int b = 0; b < 4; b++) begin
                                if (s[b]) ref_mem[a[2 +: 4]][b*8 +: 8] = d[b*8 +: 8];
                            end
                        end
                    end else if (kind == "R") begin
                        request_count++;
                        model = (predict_response(a) == axi_pkg::OKAY) ? ref_mem[a[2 +: 4]] : '0;
                        if (model !== d) begin
                            other_errors++;
                            $display("Data file expects %h at address %h, reference memory holds %h",
                                     d, a, model);
                        end
                        exp_rd_resp.push_back(predict_response(a));
                        exp_rd_data.push_back(d);
                    end
                end
            end
        end
    endtask

    // Push strobe stays up until the queue has room at an edge
    task feed_writes;
        begin
            for (int i = 0; i < wr_q.size(); i++) begin
                write_push_i <= 1'b1;
                write_request_i <= wr_q[i];
                @(posedge axi_ACLK);
                while (write_full_o) begin
                    saw_write_full = 1'b1;
                    @(posedge axi_ACLK);
                end
                wr_accepted++;
            end
            write_push_i <= 1'b0;
        end
    endtask

    task feed_reads;
        begin
            for (int i = 0; i < rd_q.size(); i++) begin
                read_push_i <= 1'b1;
                read_request_i <= rd_q[i];
                @(posedge axi_ACLK);
                while (read_full_o) begin
                    saw_read_full = 1'b1;
                    @(posedge axi_ACLK);
                end
                rd_accepted++;
            end
            read_push_i <= 1'b0;
        end
    endtask

    // Mode 0 steady, 1 random clear-to-send, 2 held low while the queues fill
    task drive_router(input logic [1:0] mode);
        case (mode)
            2'd1: begin
                while (!phase_done) begin
                    @(posedge axi_ACLK);
                    router_write_cts_i <= ($urandom % 2) != 0;
                    router_read_cts_i <= ($urandom % 2) != 0;
                end
            end
            2'd2: begin
                router_write_cts_i <= 1'b0;
                router_read_cts_i <= 1'b0;
                repeat (24) @(posedge axi_ACLK);
                router_write_cts_i <= 1'b1;
                router_read_cts_i <= 1'b1;
            end
            default: begin
                router_write_cts_i <= 1'b1;
                router_read_cts_i <= 1'b1;
            end
        endcase
    endtask

    // A phase ends only when every one of its transactions reported done
    task run_phase(input logic [1:0] mode);
        begin
            wr_target += wr_q.size();
            rd_target += rd_q.size();
            phase_done = 1'b0;
            saw_write_full = 1'b0;
            saw_read_full = 1'b0;
            @(posedge axi_ACLK);
            fork
                begin
                    fork
                        feed_writes();
                        feed_reads();
                    join
                    wait (wr_done_count == wr_target && rd_done_count == rd_target);
                    phase_done = 1'b1;
                end
                drive_router(mode);
            join
            router_write_cts_i <= 1'b1;
            router_read_cts_i <= 1'b1;
            if (mode == 2'd2 && !saw_write_full) begin
                other_errors++;
                $display("Write queue never reported full during the back-pressure phase");
            end
            if (mode == 2'd2 && !saw_read_full) begin
                other_errors++;
                $display("Read queue never reported full during the back-pressure phase");
            end
            wr_q.delete();
            rd_q.delete();
        end
    endtask

    task run_requests;
        logic [1:0] mode;
        begin
            mode = 2'd0;
            for (int i = 0; i < kind_q.size(); i++) begin
                if (kind_q[i] == "P") begin
                    if (wr_q.size() + rd_q.size() > 0) run_phase(mode);
                    mode = addr_q[i][1:0];
                end else if (kind_q[i] == "W") begin
                    wr_q.push_back('{addr: addr_q[i], data: data_q[i], strobe: aux_q[i][3:0]});
                end else begin
                    rd_q.push_back('{addr: addr_q[i]});
                end
            end
            if (wr_q.size() + rd_q.size() > 0) run_phase(mode);
        end
    endtask

    // Done pulses, sampled before the edge updates the DUT
    always @(posedge axi_ACLK) begin
        if (axi_ARESETN) begin
            if (write_done_o) begin
                if (!router_write_cts_i) begin
                    other_errors++;
                    $display("Write done at %0t while write clear-to-send was low", $time);
                end
                // Each done must belong to an accepted push still in flight
                if (wr_done_count >= wr_accepted) begin
                    other_errors++;
                    $display("Write done at %0t with no write outstanding", $time);
                end else begin
                    check_response("write_response_o", exp_wr_resp.pop_front(), write_response_o);
                end
                wr_done_count++;
            end
            if (read_done_o) begin
                if (!router_read_cts_i) begin
                    other_errors++;
                    $display("Read done at %0t while read clear-to-send was low", $time);
                end
                if (rd_done_count >= rd_accepted) begin
                    other_errors++;
                    $display("Read done at %0t with no read outstanding", $time);
                end else begin
                    check_response("read_response_o", exp_rd_resp.pop_front(), read_response_o);
                    check_data("read_data_o", exp_rd_data.pop_front(), read_data_o);
                end
                rd_done_count++;
            end
        end
    end

    initial begin
        int fd;
        axi_ARESETN <= 1'b0;
        write_push_i <= 1'b0;
        write_request_i <= '0;
        read_push_i <= 1'b0;
        read_request_i <= '0;
        router_write_cts_i <= 1'b1;
        router_read_cts_i <= 1'b1;
        void'($urandom(59));
        fd = $fopen("testbench/axi_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testbench/axi_testdata.txt");
            $display("Errors found");
            $finish;
        end else begin
            load_requests(fd);
            $fclose(fd);
            // 64 cycles per request plus the 10 reset cycles
            fork
                begin
                    repeat (request_count * 64 + 10) @(posedge axi_ACLK);
                    $display("Watchdog timeout with transactions still outstanding");
                    $display("Errors found");
                    $finish;
                end
            join_none
            repeat (10) @(posedge axi_ACLK);
            axi_ARESETN <= 1'b1;
            run_requests();
            // Quiet bus for a while, so a stray late done still shows up
            repeat (16) @(posedge axi_ACLK);
            if (wr_done_count != wr_accepted || rd_done_count != rd_accepted) begin
                other_errors++;
                $display("Done pulse count does not match the number of accepted pushes");
            end
            $display("Checks finished: %0d value errors, %0d other errors",
                     value_errors, other_errors);
            if (value_errors + other_errors == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

endmodule : axi_subsystem_tb

/* testbench/axi_testdata.txt */
# Columns: P mode | W address data strobe | R address expected_data (all hex)
# Modes: 0 steady clear-to-send, 1 random clear-to-send, 2 back-pressure
P 0
W 00000000 11223344 f
W 00000004 a5a5a5a5 f
W 0000003c deadbeef f
P 0
R 00000000 11223344
R 00000004 a5a5a5a5
R 0000003c deadbeef
P 0
W 00000000 cafebabe 3
W 00000004 00ff0000 4
W 00000040 ffffffff f
W 00000008 01020304 f
R 00000080 00000000
R 0000003c deadbeef
P 0
R 00000000 1122babe
R 00000004 a5ffa5a5
R 00000008 01020304
R 00000040 00000000
P 1
W 00000010 10101010 f
W 00000014 14141414 c
R 00000000 1122babe
R 0000003c deadbeef
P 2
W 00000020 20202020 f
W 00000024 24242424 f
W 00000028 28282828 f
W 0000002c 2c2c2c2c f
W 00000030 30303030 f
R 00000004 a5ffa5a5
R 00000008 01020304
R 00000010 10101010
R 00000014 14140000
R 0000003c deadbeef
